// File: dv/forth_model.svh
// Expected TX bytes and LED state of the dictionary words
// A digit must be followed by "." or "led", only the last number is kept
// LED vector is {led_r, led_g, led_b}, active low
`ifndef FORTH_MODEL_SVH
`define FORTH_MODEL_SVH

// Bytes expected on TX for the current line
logic [7:0] exp_bytes [$];
// LED state after the last settled line
logic [2:0] exp_leds;
// Last number pushed by a digit word
logic [3:0] model_num;

// Single decimal digit
function automatic bit is_digit_word(input string w);
	return (w.len() == 1) && (w[0] >= "0") && (w[0] <= "9");
endfunction

// Names held in the dictionary
function automatic bit is_dict_word(input string w);
	return (w == "red") || (w == "green") || (w == "blue") ||
		(w == "delay") || (w == "led") || (w == ".");
endfunction

// Power-up state, all LEDs dark
function automatic void model_reset();
	exp_bytes.delete();
	exp_leds  = 3'b111;
	model_num = '0;
endfunction

// Effect of one word on TX and the LEDs
function automatic void model_word(input string w);
	if (w == "red")
		exp_leds = 3'b011;
	else if (w == "green")
		exp_leds = 3'b101;
	else if (w == "blue")
		exp_leds = 3'b110;
	// Only burns time
	else if (w == "delay")
		exp_leds = exp_leds;
	// Lit where the number has a 1, bit 0 green, bit 1 blue, bit 2 red
	else if (w == "led")
		exp_leds = {~model_num[2], ~model_num[0], ~model_num[1]};
	else if (w == ".") begin
		exp_bytes.push_back(8'h20);
		exp_bytes.push_back(8'h30 + 8'(model_num));
	end else if (is_digit_word(w))
		model_num = 4'(w[0] - "0");
	else
		exp_bytes.push_back("?");
endfunction

`endif

// File: dv/tb_forth.sv
// Drives forth_core over its serial line with random lines from a fixed LFSR seed
// Each line is sent only after the previous one has settled
`timescale 1ns/1ps

module tb_forth import forth_pkg::*; ();

	localparam int CHAR_CLKS = 10 * CLKS_PER_BIT;

	logic        clk;
	logic        reset;
	logic        rx;
	logic        tx;
	logic        led_r;
	logic        led_g;
	logic        led_b;
	logic [31:0] lfsr;
	// Bytes decoded from TX
	logic [7:0]  got_bytes [$];
	logic [7:0]  mon_byte;
	logic        mon_busy;
	string       line_words [$];

	`include "forth_model.svh"

	forth_core dut0 (.clk, .reset, .rx, .tx, .led_r, .led_g, .led_b);

	always #2 clk = ~clk;

	//////////////////////////////////////////////////////////////////////
	// Failure reporting and compares
	//////////////////////////////////////////////////////////////////////

	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("TEST RESULT: FAIL");
		$fatal(1);
	endtask

	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp)
			fail_now($sformatf("MISMATCH %s: got 0x%02h expected 0x%02h", name, got, exp));
	endtask

	task automatic check_leds(input string name, input logic [2:0] got, input logic [2:0] exp);
		if (got !== exp)
			fail_now($sformatf("MISMATCH %s: got 0x%01h expected 0x%01h", name, got, exp));
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp)
			fail_now($sformatf("MISMATCH %s: got 0x%0h expected 0x%0h", name, got, exp));
	endtask

	//////////////////////////////////////////////////////////////////////
	// Random source
	//////////////////////////////////////////////////////////////////////

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// One LFSR step per bit
	function automatic int unsigned rand_bits(input int n);
		int unsigned v;
		v = 0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			v    = (v << 1) | 32'(lfsr[0]);
		end
		return v;
	endfunction

	function automatic int rand_below(input int n);
		return int'(rand_bits(8) % n);
	endfunction

	// Lower case letters, renamed if it hits a dictionary name
	function automatic string pick_unknown();
		string w;
		int    n;
		w = "";
		n = 1 + rand_below(5);
		for (int i = 0; i < n; i++)
			w = $sformatf("%s%c", w, 8'h61 + 8'(rand_below(26)));
		if (is_dict_word(w))
			w = {w, "x"};
		return w;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Serial driver and TX monitor
	//////////////////////////////////////////////////////////////////////

	// Start bit, LSB first, stop bit
	task automatic send_char(input logic [7:0] c);
		logic [9:0] frame;
		frame = {1'b1, c, 1'b0};
		for (int i = 0; i < 10; i++) begin
			rx <= frame[i];
			repeat (CLKS_PER_BIT) @(posedge clk);
		end
	endtask

	// Sampled on the falling edge, away from the DUT updates
	always begin
		@(negedge clk);
		if (reset && !tx) begin
			mon_busy = 1'b1;
			repeat (CLKS_PER_BIT / 2) @(negedge clk);
			if (tx !== 1'b0)
				fail_now("TX start bit ended early");
			for (int i = 0; i < 8; i++) begin
				repeat (CLKS_PER_BIT) @(negedge clk);
				mon_byte[i] = tx;
			end
			repeat (CLKS_PER_BIT) @(negedge clk);
			if (tx !== 1'b1)
				fail_now("TX stop bit missing");
			got_bytes.push_back(mon_byte);
			mon_busy = 1'b0;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Line handling
	//////////////////////////////////////////////////////////////////////

	// Wait for the expected bytes, then for a quiet TX
	task automatic settle_line();
		int waited;
		int quiet;
		int limit;
		limit  = (exp_bytes.size() + 4) * CHAR_CLKS;
		waited = 0;
		while (got_bytes.size() < exp_bytes.size()) begin
			if (waited >= limit)
				fail_now("Timeout waiting for bytes on TX");
			@(posedge clk);
			waited++;
		end
		waited = 0;
		quiet  = 0;
		while (quiet < 2 * CHAR_CLKS) begin
			if (waited >= 8 * CHAR_CLKS)
				fail_now("TX did not settle after the line");
			@(posedge clk);
			waited++;
			quiet = mon_busy ? 0 : quiet + 1;
		end
		check_count("tx_byte_count", got_bytes.size(), exp_bytes.size());
		foreach (exp_bytes[i])
			check_byte("tx_byte", got_bytes[i], exp_bytes[i]);
		check_leds("leds", {led_r, led_g, led_b}, exp_leds);
	endtask

	// Words separated by spaces, CR at the end
	task automatic run_line();
		string w;
		exp_bytes.delete();
		got_bytes.delete();
		foreach (line_words[i]) begin
			w = line_words[i];
			model_word(w);
			for (int k = 0; k < w.len(); k++)
				send_char(w[k]);
			send_char((i == line_words.size() - 1) ? CHAR_CR : 8'h20);
		end
		settle_line();
		line_words.delete();
	endtask

	// Up to six words, a digit always followed by "." or "led"
	task automatic random_line();
		int n;
		int kind;
		n = 1 + rand_below(6);
		while (line_words.size() < n) begin
			kind = rand_below(6);
			if (kind == 5 && line_words.size() + 2 > n)
				kind = rand_below(5);
			case (kind)
				0: line_words.push_back("red");
				1: line_words.push_back("green");
				2: line_words.push_back("blue");
				3: line_words.push_back("delay");
				4: line_words.push_back(pick_unknown());
				default: begin
					line_words.push_back($sformatf("%0d", rand_below(10)));
					if (rand_bits(1))
						line_words.push_back(".");
					else
						line_words.push_back("led");
				end
			endcase
		end
		run_line();
	endtask

	//////////////////////////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		clk      = 1'b0;
		reset    = 1'b0;
		rx       = 1'b1;
		mon_busy = 1'b0;
		lfsr     = 32'h23ab;
		model_reset();
		repeat (3) @(posedge clk);
		reset <= 1'b1;

		// Idle after reset
		for (int i = 0; i < 2 * CHAR_CLKS; i++) begin
			@(posedge clk);
			if (tx !== 1'b1)
				fail_now("TX left the idle level after reset");
		end
		check_count("tx_byte_count", got_bytes.size(), 0);
		check_leds("leds", {led_r, led_g, led_b}, exp_leds);

		// Colour words
		line_words.push_back("red");
		run_line();
		line_words.push_back("green");
		run_line();
		line_words.push_back("blue");
		run_line();

		// Digit then dot, digit then led
		for (int i = 0; i < 4; i++) begin
			line_words.push_back($sformatf("%0d", rand_below(10)));
			line_words.push_back(".");
			run_line();
		end
		for (int i = 0; i < 4; i++) begin
			line_words.push_back($sformatf("%0d", rand_below(10)));
			line_words.push_back("led");
			run_line();
		end

		// Unknown words
		for (int i = 0; i < 4; i++) begin
			line_words.push_back(pick_unknown());
			run_line();
		end

		// Mixed lines
		for (int i = 0; i < 8; i++)
			random_line();

		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

// File: run.sh
#!/usr/bin/env bash
# Builds the Forth core testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_forth -f tb.f -o tb_forth

# The log decides the result
./obj_dir/tb_forth 2>&1 | tee sim.log

grep -q "TEST RESULT: PASS" sim.log

// File: src/boot_rom.sv
// Code words of the boot program, every word ends with a branch to 0
// Unused addresses read as op_execute
`timescale 1ns/1ps

module boot_rom import forth_pkg::*; (
	input  logic [CODE_ADDR_W-1:0] code_addr,
	output code_cell_u             code_cell
);

	always_comb begin
		code_cell = '0;
		case (code_addr)
			// Wait for the next token
			6'd0:  code_cell.code.op = op_execute;
			// Unknown word
			6'd1:  code_cell.code.op = op_lit;
			6'd2:  code_cell.value   = {24'h0, "?"};
			6'd3:  code_cell.code.op = op_emit;
			6'd4:  code_cell.code.op = op_branch;
			6'd5:  code_cell.value   = 32'd0;
			// red
			6'd6:  code_cell.code.op = op_lit;
			6'd7:  code_cell.value   = 32'd4;
			6'd8:  code_cell.code.op = op_io_led;
			6'd9:  code_cell.code.op = op_branch;
			6'd10: code_cell.value   = 32'd0;
			// green
			6'd11: code_cell.code.op = op_lit;
			6'd12: code_cell.value   = 32'd1;
			6'd13: code_cell.code.op = op_io_led;
			6'd14: code_cell.code.op = op_branch;
			6'd15: code_cell.value   = 32'd0;
			// blue
			6'd16: code_cell.code.op = op_lit;
			6'd17: code_cell.value   = 32'd2;
			6'd18: code_cell.code.op = op_io_led;
			6'd19: code_cell.code.op = op_branch;
			6'd20: code_cell.value   = 32'd0;
			// Digit from the token
			6'd21: code_cell.code.op = op_number;
			6'd22: code_cell.code.op = op_branch;
			6'd23: code_cell.value   = 32'd0;
			// led
			6'd24: code_cell.code.op = op_io_led;
			6'd25: code_cell.code.op = op_branch;
			6'd26: code_cell.value   = 32'd0;
			// delay, count down to zero
			6'd27: code_cell.code.op = op_lit;
			6'd28: code_cell.value   = 32'(DELAY_COUNT);
			6'd29: code_cell.code.op = op_lit;
			6'd30: code_cell.value   = 32'd1;
			6'd31: code_cell.code.op = op_minus;
			6'd32: code_cell.code.op = op_dup;
			6'd33: code_cell.code.op = op_zero_equal;
			6'd34: code_cell.code.op = op_zbranch;
			6'd35: code_cell.value   = 32'd29;
			6'd36: code_cell.code.op = op_drop;
			6'd37: code_cell.code.op = op_branch;
			6'd38: code_cell.value   = 32'd0;
			// Dot, space then one digit
			6'd39: code_cell.code.op = op_lit;
			6'd40: code_cell.value   = {24'h0, " "};
			6'd41: code_cell.code.op = op_emit;
			6'd42: code_cell.code.op = op_lit;
			6'd43: code_cell.value   = {24'h0, "0"};
			6'd44: code_cell.code.op = op_plus;
			6'd45: code_cell.code.op = op_emit;
			6'd46: code_cell.code.op = op_branch;
			6'd47: code_cell.value   = 32'd0;
			default: code_cell = '0;
		endcase
	end

endmodule

// File: src/dictionary_rom.sv
// Word dictionary as a linked list, link 0 ends the list
// Entry is link, name cells, code address; read data one cycle after the address
`timescale 1ns/1ps

module dictionary_rom import forth_pkg::*; (
	input  logic                   clk,
	input  logic [DICT_ADDR_W-1:0] dict_addr,
	output dict_cell_u             dict_cell
);

	always_ff @(posedge clk) begin
		case (dict_addr)
			// red
			5'd0:    dict_cell.raw <= 32'd3;
			5'd1:    dict_cell.raw <= {8'd1, "red"};
			5'd2:    dict_cell.raw <= 32'd6;
			// green
			5'd3:    dict_cell.raw <= 32'd7;
			5'd4:    dict_cell.raw <= {8'd2, "gre"};
			5'd5:    dict_cell.raw <= {"en", 16'h0};
			5'd6:    dict_cell.raw <= 32'd11;
			// blue
			5'd7:    dict_cell.raw <= 32'd11;
			5'd8:    dict_cell.raw <= {8'd2, "blu"};
			5'd9:    dict_cell.raw <= {"e", 24'h0};
			5'd10:   dict_cell.raw <= 32'd16;
			// delay
			5'd11:   dict_cell.raw <= 32'd15;
			5'd12:   dict_cell.raw <= {8'd2, "del"};
			5'd13:   dict_cell.raw <= {"ay", 16'h0};
			5'd14:   dict_cell.raw <= 32'd27;
			// led
			5'd15:   dict_cell.raw <= 32'd18;
			5'd16:   dict_cell.raw <= {8'd1, "led"};
			5'd17:   dict_cell.raw <= 32'd24;
			// dot, last entry
			5'd18:   dict_cell.raw <= 32'd0;
			5'd19:   dict_cell.raw <= {8'd1, ".", 16'h0};
			5'd20:   dict_cell.raw <= 32'd39;
			default: dict_cell.raw <= '0;
		endcase
	end

endmodule

// File: src/forth_core.sv
// Forth processor driven over a serial line
// One line at a time, the host waits for a line to settle
`timescale 1ns/1ps

module forth_core import forth_pkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic rx,
	output logic tx,
	output logic led_r,
	output logic led_g,
	output logic led_b
);

	logic [7:0]             rx_byte;
	logic                   rx_valid;
	logic [DICT_ADDR_W-1:0] dict_addr;
	dict_cell_u             dict_cell;
	token_t                 token;
	logic                   token_valid;
	logic                   token_pop;
	logic [CODE_ADDR_W-1:0] code_addr;
	code_cell_u             code_cell;
	logic [7:0]             tx_byte;
	logic                   tx_start;
	logic                   tx_busy;

	// Serial side
	uart_rx rx0 (.clk, .reset, .rx, .rx_byte, .rx_valid);
	uart_tx tx0 (.clk, .reset, .tx_byte, .tx_start, .tx, .tx_busy);

	// Outer interpreter with its dictionary
	dictionary_rom dict0 (.clk, .dict_addr, .dict_cell);
	outer_interp outer0 (
		.clk, .reset, .rx_byte, .rx_valid, .dict_addr, .dict_cell,
		.token, .token_valid, .token_pop
	);

	// Inner interpreter with the boot code
	boot_rom boot0 (.code_addr, .code_cell);
	inner_interp inner0 (
		.clk, .reset, .code_addr, .code_cell, .token, .token_valid, .token_pop,
		.tx_byte, .tx_start, .tx_busy, .led_r, .led_g, .led_b
	);

endmodule

// File: src/forth_pkg.sv
// Widths, opcodes and cell layouts shared by every unit of the Forth core
// CLKS_PER_BIT gives about 19200 baud from a 12 MHz clock
package forth_pkg;

	localparam int DATA_W      = 32;
	localparam int CODE_ADDR_W = 6;
	localparam int DICT_ADDR_W = 5;
	localparam int STACK_DEPTH = 16;
	localparam int STACK_PTR_W = $clog2(STACK_DEPTH);
	localparam int TOKEN_DEPTH = 8;
	localparam int TOKEN_PTR_W = $clog2(TOKEN_DEPTH);
	// Name cells per word, so seven characters at most
	localparam int NAME_CELLS  = 2;

	// UART bit timing
	localparam int CLKS_PER_BIT = 626;
	localparam int BAUD_CNT_W   = $clog2(CLKS_PER_BIT);
	localparam logic [BAUD_CNT_W-1:0] BIT_LAST = BAUD_CNT_W'(CLKS_PER_BIT - 1);
	localparam logic [BAUD_CNT_W-1:0] BIT_MID  = BAUD_CNT_W'(CLKS_PER_BIT / 2 - 1);

	// Iterations of the delay word
	localparam int DELAY_COUNT = 20;

	localparam logic [7:0] CHAR_CR = 8'h0d;
	localparam logic [7:0] CHAR_LF = 8'h0a;

	// Opcodes, op_execute is zero
	typedef enum logic [15:0] {
		op_execute, op_lit, op_plus, op_minus, op_dup, op_drop, op_equal, op_zero_equal,
		op_and, op_or, op_branch, op_zbranch, op_number, op_emit, op_io_led
	} op_e;

	// Boot ROM cell, opcode or operand
	typedef union packed {
		struct packed {
			logic [15:0] unused;
			op_e         op;
		} code;
		logic [DATA_W-1:0] value;
	} code_cell_u;

	// Dictionary cell, link and code address raw, first name cell with a count
	typedef union packed {
		logic [DATA_W-1:0] raw;
		struct packed {
			logic [7:0] count;
			logic [7:0] ch0;
			logic [7:0] ch1;
			logic [7:0] ch2;
		} name;
	} dict_cell_u;

	// One queued word
	typedef struct packed {
		logic [CODE_ADDR_W-1:0] xt;
		logic [3:0]             digit;
	} token_t;

	// Fixed entry points of the boot code
	localparam logic [CODE_ADDR_W-1:0] XT_UNKNOWN = 6'd1;
	localparam logic [CODE_ADDR_W-1:0] XT_NUMBER  = 6'd21;

endpackage

// File: src/inner_interp.sv
// Fetch/execute unit, one opcode per cycle, operand cells take a second cycle
// Data stack is circular, no underflow or overflow detection
// LEDs are active low
`timescale 1ns/1ps

module inner_interp import forth_pkg::*; (
	input  logic                   clk,
	input  logic                   reset,
	output logic [CODE_ADDR_W-1:0] code_addr,
	input  code_cell_u             code_cell,
	input  token_t                 token,
	input  logic                   token_valid,
	output logic                   token_pop,
	output logic [7:0]             tx_byte,
	output logic                   tx_start,
	input  logic                   tx_busy,
	output logic                   led_r,
	output logic                   led_g,
	output logic                   led_b
);

	typedef enum logic [1:0] {II_EXEC, II_OPND, II_EMIT} ii_state_e;

	ii_state_e              state;
	op_e                    op;
	op_e                    op_q;
	logic                   exec;
	logic [CODE_ADDR_W-1:0] pc;
	logic [STACK_PTR_W-1:0] dp;
	logic [STACK_PTR_W-1:0] dp_up;
	logic [STACK_PTR_W-1:0] dp_dn;
	logic [STACK_PTR_W-1:0] dp_next;
	logic [DATA_W-1:0]      data_stack [STACK_DEPTH];
	logic [DATA_W-1:0]      tos;
	logic [DATA_W-1:0]      nos;
	logic                   st_we;
	logic [STACK_PTR_W-1:0] st_wa;
	logic [DATA_W-1:0]      st_wd;
	logic [3:0]             num;

	assign code_addr = pc;
	assign op        = code_cell.code.op;
	assign exec      = state == II_EXEC;
	assign dp_up     = dp + 1'b1;
	assign dp_dn     = dp - 1'b1;
	assign tos       = data_stack[dp];
	assign nos       = data_stack[dp_dn];

	assign token_pop = exec && (op == op_execute) && token_valid;
	assign tx_start  = exec && (op == op_emit);
	assign tx_byte   = tos[7:0];

	//////////////////////////////////////////////////////////////////////
	// Stack write port
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		st_we   = 1'b0;
		st_wa   = dp_up;
		st_wd   = nos + tos;
		dp_next = dp;
		if (state == II_OPND) begin
			// Literal pushes, zero-branch pops its flag
			if (op_q == op_lit) begin
				st_we   = 1'b1;
				st_wd   = code_cell.value;
				dp_next = dp_up;
			end else if (op_q == op_zbranch) begin
				dp_next = dp_dn;
			end
		end else if (exec) begin
			case (op)
				op_plus, op_minus, op_equal, op_and, op_or: begin
					st_we   = 1'b1;
					st_wa   = dp_dn;
					dp_next = dp_dn;
					if (op == op_minus)
						st_wd = nos - tos;
					else if (op == op_equal)
						st_wd = {DATA_W{nos == tos}};
					else if (op == op_and)
						st_wd = nos & tos;
					else if (op == op_or)
						st_wd = nos | tos;
				end
				op_dup: begin
					st_we   = 1'b1;
					st_wd   = tos;
					dp_next = dp_up;
				end
				op_number: begin
					st_we   = 1'b1;
					st_wd   = DATA_W'(num);
					dp_next = dp_up;
				end
				op_zero_equal: begin
					st_we = 1'b1;
					st_wa = dp;
					st_wd = {DATA_W{tos == '0}};
				end
				op_drop, op_emit, op_io_led: dp_next = dp_dn;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (st_we)
			data_stack[st_wa] <= st_wd;
	end

	//////////////////////////////////////////////////////////////////////
	// Sequencing
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!reset) begin
			state <= II_EXEC;
			op_q  <= op_execute;
			pc    <= '0;
			dp    <= '0;
			led_r <= 1'b1;
			led_g <= 1'b1;
			led_b <= 1'b1;
		end else begin
			dp <= dp_next;
			case (state)
				II_EXEC: begin
					case (op)
						// Stall here until a token is released
						op_execute: if (token_valid) begin
							pc  <= token.xt;
							num <= token.digit;
						end
						op_lit, op_branch, op_zbranch: begin
							op_q  <= op;
							pc    <= pc + 1'b1;
							state <= II_OPND;
						end
						op_emit: begin
							pc    <= pc + 1'b1;
							state <= II_EMIT;
						end
						op_io_led: begin
							led_g <= ~tos[0];
							led_b <= ~tos[1];
							led_r <= ~tos[2];
							pc    <= pc + 1'b1;
						end
						default: pc <= pc + 1'b1;
					endcase
				end
				// Operand cell
				II_OPND: begin
					state <= II_EXEC;
					if (op_q == op_branch || (op_q == op_zbranch && tos == '0))
						pc <= code_cell.value[CODE_ADDR_W-1:0];
					else
						pc <= pc + 1'b1;
				end
				// Hold until the byte has left
				II_EMIT: if (!tx_busy)
					state <= II_EXEC;
				default: state <= II_EXEC;
			endcase
		end
	end

	// Control never lands on an operand or a cell outside the opcode set
	a_known_op: assert property (@(posedge clk) disable iff (!reset)
		exec |-> (code_cell.code.op <= op_io_led))
		else $error("unknown opcode fetched");

endmodule

// File: src/outer_interp.sv
// Words of up to seven characters, longer ones are reported unknown
// At most TOKEN_DEPTH words wait in the queue, a CR or LF releases them
// Bytes are taken only between searches, a search ends well within a character time
`timescale 1ns/1ps

module outer_interp import forth_pkg::*; (
	input  logic                   clk,
	input  logic                   reset,
	input  logic [7:0]             rx_byte,
	input  logic                   rx_valid,
	output logic [DICT_ADDR_W-1:0] dict_addr,
	input  dict_cell_u             dict_cell,
	output token_t                 token,
	output logic                   token_valid,
	input  logic                   token_pop
);

	typedef enum logic [2:0] {OI_IDLE, OI_LINK, OI_NAME, OI_XT, OI_MISS, OI_PUSH} oi_state_e;

	oi_state_e              state;
	dict_cell_u             name_buf [NAME_CELLS];
	logic [2:0]             len;
	logic [2:0]             pos;
	logic                   too_long;
	logic                   eol;
	logic                   rd_wait;
	logic [DICT_ADDR_W-1:0] link;
	logic                   cell_idx;
	logic                   last_cell;
	logic                   single_digit;
	logic                   is_space;
	logic                   is_eol;
	token_t                 new_tok;
	token_t                 queue [TOKEN_DEPTH];
	logic [TOKEN_PTR_W:0]   wr_ptr;
	logic [TOKEN_PTR_W:0]   rd_ptr;
	logic [TOKEN_PTR_W:0]   rel_ptr;
	logic [TOKEN_PTR_W:0]   q_fill;

	// Byte slot of the next character, slot 0 is the count
	assign pos          = len + 3'd1;
	assign is_space     = rx_byte == " ";
	assign is_eol       = (rx_byte == CHAR_CR) || (rx_byte == CHAR_LF);
	assign last_cell    = cell_idx == (name_buf[0].name.count == 8'd2);
	assign single_digit = (len == 3'd1) && (name_buf[0].name.ch0 inside {["0":"9"]});

	//////////////////////////////////////////////////////////////////////
	// Parser and dictionary walk
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!reset) begin
			state            <= OI_IDLE;
			name_buf[0].raw  <= '0;
			name_buf[1].raw  <= '0;
			len              <= '0;
			too_long         <= 1'b0;
			eol              <= 1'b0;
			rd_wait          <= 1'b0;
			dict_addr        <= '0;
			link             <= '0;
			cell_idx         <= 1'b0;
			wr_ptr           <= '0;
			rd_ptr           <= '0;
			rel_ptr          <= '0;
		end else begin
			rd_wait <= 1'b0;
			if (token_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case (state)
				OI_IDLE: if (rx_valid) begin
					if (is_space || is_eol) begin
						eol       <= is_eol;
						dict_addr <= '0;
						rd_wait   <= 1'b1;
						// Empty word, a line end still releases what is pending
						if (len == '0) begin
							if (is_eol)
								rel_ptr <= wr_ptr;
						end else if (too_long) begin
							state <= OI_MISS;
						end else begin
							state <= OI_LINK;
						end
					end else if (len == 3'd7) begin
						too_long <= 1'b1;
					end else begin
						name_buf[pos[2]].raw[{~pos[1:0], 3'b000} +: 8] <= rx_byte;
						name_buf[0].name.count <= pos[2] ? 8'd2 : 8'd1;
						len <= pos;
					end
				end
				// Link of the current entry
				OI_LINK: if (!rd_wait) begin
					link      <= dict_cell.raw[DICT_ADDR_W-1:0];
					dict_addr <= dict_addr + 1'b1;
					cell_idx  <= 1'b0;
					rd_wait   <= 1'b1;
					state     <= OI_NAME;
				end
				// Whole cells compared, count byte included
				OI_NAME: if (!rd_wait) begin
					rd_wait <= 1'b1;
					if (dict_cell.raw != name_buf[cell_idx].raw) begin
						dict_addr <= link;
						state     <= (link == '0) ? OI_MISS : OI_LINK;
					end else begin
						dict_addr <= dict_addr + 1'b1;
						cell_idx  <= 1'b1;
						if (last_cell)
							state <= OI_XT;
					end
				end
				OI_XT: if (!rd_wait) begin
					new_tok.xt    <= dict_cell.raw[CODE_ADDR_W-1:0];
					new_tok.digit <= '0;
					state         <= OI_PUSH;
				end
				// Not in the dictionary
				OI_MISS: begin
					new_tok.xt    <= single_digit ? XT_NUMBER : XT_UNKNOWN;
					new_tok.digit <= name_buf[0].name.ch0[3:0];
					state         <= OI_PUSH;
				end
				OI_PUSH: begin
					wr_ptr          <= wr_ptr + 1'b1;
					name_buf[0].raw <= '0;
					name_buf[1].raw <= '0;
					len             <= '0;
					too_long        <= 1'b0;
					if (eol)
						rel_ptr <= wr_ptr + 1'b1;
					state <= OI_IDLE;
				end
				default: state <= OI_IDLE;
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Token queue, released part between rd_ptr and rel_ptr
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (state == OI_PUSH)
			queue[wr_ptr[TOKEN_PTR_W-1:0]] <= new_tok;
	end

	assign token       = queue[rd_ptr[TOKEN_PTR_W-1:0]];
	assign token_valid = rd_ptr != rel_ptr;
	assign q_fill      = wr_ptr - rd_ptr;

	// Inner interpreter must drain a line before it grows past the queue
	a_no_overflow: assert property (@(posedge clk) disable iff (!reset)
		(state == OI_PUSH) |-> (q_fill < TOKEN_DEPTH))
		else $error("token queue overflow");

	// A pop may only take a released token
	a_pop_released: assert property (@(posedge clk) disable iff (!reset)
		token_pop |-> token_valid)
		else $error("token_pop without a released token");

endmodule

// File: src/uart_rx.sv
// 8N1 receiver, LSB first, no parity
// One rx_valid strobe per character in the middle of the stop bit
// Characters with a low stop bit are dropped
`timescale 1ns/1ps

module uart_rx import forth_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       rx,
	output logic [7:0] rx_byte,
	output logic       rx_valid
);

	typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

	rx_state_e             state;
	logic [1:0]            rx_sync;
	logic                  rx_s;
	logic [BAUD_CNT_W-1:0] clk_cnt;
	logic [2:0]            bit_cnt;
	logic                  sample;

	// Resynchronized line
	assign rx_s = rx_sync[1];
	// Middle of a data bit
	assign sample = (state == RX_DATA) && (clk_cnt == BIT_LAST);

	always_ff @(posedge clk) begin
		if (!reset) begin
			rx_sync  <= 2'b11;
			state    <= RX_IDLE;
			clk_cnt  <= '0;
			bit_cnt  <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_sync  <= {rx_sync[0], rx};
			rx_valid <= 1'b0;
			clk_cnt  <= clk_cnt + 1'b1;
			case (state)
				RX_IDLE: begin
					clk_cnt <= '0;
					if (!rx_s)
						state <= RX_START;
				end
				// Glitch filter, start bit must still be low half a bit later
				RX_START: if (clk_cnt == BIT_MID) begin
					clk_cnt <= '0;
					bit_cnt <= '0;
					state   <= rx_s ? RX_IDLE : RX_DATA;
				end
				RX_DATA: if (sample) begin
					clk_cnt <= '0;
					bit_cnt <= bit_cnt + 1'b1;
					if (bit_cnt == 3'd7)
						state <= RX_STOP;
				end
				RX_STOP: if (clk_cnt == BIT_LAST) begin
					rx_valid <= rx_s;
					state    <= RX_IDLE;
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

	// Data shift register, LSB arrives first
	always_ff @(posedge clk) begin
		if (sample)
			rx_byte <= {rx_s, rx_byte[7:1]};
	end

endmodule

// File: src/uart_tx.sv
// 8N1 transmitter, LSB first
// tx_start is taken only while tx_busy is low
`timescale 1ns/1ps

module uart_tx import forth_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic [7:0] tx_byte,
	input  logic       tx_start,
	output logic       tx,
	output logic       tx_busy
);

	logic [8:0]            shreg;
	logic [BAUD_CNT_W-1:0] clk_cnt;
	logic [3:0]            bit_cnt;
	logic                  bit_end;

	assign bit_end = tx_busy && (clk_cnt == BIT_LAST);

	always_ff @(posedge clk) begin
		if (!reset) begin
			tx      <= 1'b1;
			tx_busy <= 1'b0;
			clk_cnt <= '0;
			bit_cnt <= '0;
		end else if (!tx_busy) begin
			clk_cnt <= '0;
			bit_cnt <= '0;
			// Start bit goes out on the next cycle
			if (tx_start) begin
				tx      <= 1'b0;
				tx_busy <= 1'b1;
			end
		end else if (bit_end) begin
			clk_cnt <= '0;
			// Stop bit finished
			if (bit_cnt == 4'd9) begin
				tx_busy <= 1'b0;
			end else begin
				tx      <= shreg[0];
				bit_cnt <= bit_cnt + 1'b1;
			end
		end else begin
			clk_cnt <= clk_cnt + 1'b1;
		end
	end

	// Latched byte with the stop bit on top
	always_ff @(posedge clk) begin
		if (tx_start && !tx_busy)
			shreg <= {1'b1, tx_byte};
		else if (bit_end)
			shreg <= {1'b1, shreg[8:1]};
	end

	// Emit must wait for the previous byte
	a_no_start_busy: assert property (@(posedge clk) disable iff (!reset)
		tx_start |-> !tx_busy)
		else $error("tx_start while transmitter busy");

endmodule

// File: tb.f
+incdir+dv
src/forth_pkg.sv
src/uart_rx.sv
src/uart_tx.sv
src/dictionary_rom.sv
src/outer_interp.sv
src/boot_rom.sv
src/inner_interp.sv
src/forth_core.sv
dv/tb_forth.sv
